//--- rtl/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// fetch address and its fields
`define ICACHE_ADDR_WIDTH    32
`define ICACHE_OFFSET_BITS   6   // byte offset within a 64-byte line
`define ICACHE_BANK_SEL_BITS 2   // addr[5:4]
`define ICACHE_SET_BITS      4   // addr[9:6]
`define ICACHE_TAG_BITS      22  // addr[31:10]

// geometry
`define ICACHE_WAY_NUM       2
`define ICACHE_BANK_NUM      4
`define ICACHE_BANK_WIDTH    128
`define ICACHE_LINE_WIDTH    512

// victim lfsr, x^8 + x^6 + x^5 + x^4 + 1
`define ICACHE_LFSR_SEED     8'hA5
`define ICACHE_LFSR_TAPS     8'hB8

`endif

//--- rtl/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

    // controller states
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_MEM_REQ,
        ST_MEM_WAIT,
        ST_REFILL
    } icache_state_t;

    typedef logic [`ICACHE_TAG_BITS-1:0]      tag_t;
    typedef logic [`ICACHE_SET_BITS-1:0]      set_idx_t;
    typedef logic [`ICACHE_BANK_SEL_BITS-1:0] bank_sel_t;
    typedef logic                             way_t;
    typedef logic [`ICACHE_BANK_WIDTH-1:0]    bank_word_t;
    typedef logic [`ICACHE_LINE_WIDTH-1:0]    line_t;  // bank 0 in the low bits

endpackage

//--- rtl/icache_tag_lookup.sv
`include "icache_params.svh"

module icache_tag_lookup
    import icache_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          lookup_start,
    input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr,
    input  logic                          refill_en,
    output logic                          hit,
    output way_t                          hit_way,
    output way_t                          victim_way,
    output logic [`ICACHE_ADDR_WIDTH-1:0] line_addr
);

    localparam int SET_NUM = 1 << `ICACHE_SET_BITS;
    localparam int TAG_LO  = `ICACHE_OFFSET_BITS + `ICACHE_SET_BITS;

    tag_t                                     tag_mem [`ICACHE_WAY_NUM][SET_NUM];
    logic [`ICACHE_WAY_NUM-1:0][SET_NUM-1:0]  valid_bits;

    set_idx_t                    fetch_set;
    tag_t                        fetch_tag;
    tag_t                        req_tag;
    set_idx_t                    req_set;
    tag_t                        rd_tag [`ICACHE_WAY_NUM];
    logic [`ICACHE_WAY_NUM-1:0]  rd_valid;
    logic [`ICACHE_WAY_NUM-1:0]  way_hit;
    logic [7:0]                  lfsr;
    way_t                        rand_way;

    assign fetch_set = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign fetch_tag = fetch_addr[TAG_LO +: `ICACHE_TAG_BITS];

    // tag array read and request latch, refill writes the latched tag
    always_ff @(posedge clock) begin
        if (lookup_start) begin
            req_tag <= fetch_tag;
            req_set <= fetch_set;
            for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
                rd_tag[w] <= tag_mem[w][fetch_set];
            end
        end
        if (refill_en) begin
            tag_mem[victim_way][req_set] <= req_tag;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_bits <= '0;
            rd_valid   <= '0;
            lfsr       <= `ICACHE_LFSR_SEED;
            rand_way   <= 1'b0;
        end else begin
            lfsr <= {lfsr[6:0], ^(lfsr & `ICACHE_LFSR_TAPS)};  // free running
            if (lookup_start) begin
                for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
                    rd_valid[w] <= valid_bits[w][fetch_set];
                end
                rand_way <= lfsr[0];  // frozen for this request
            end
            if (refill_en) begin
                valid_bits[victim_way][req_set] <= 1'b1;
            end
        end
    end

    // compare against the latched read
    always_comb begin
        for (int w = 0; w < `ICACHE_WAY_NUM; w++) begin
            way_hit[w] = rd_valid[w] && (rd_tag[w] == req_tag);
        end
    end

    assign hit     = |way_hit;
    assign hit_way = way_hit[1];  // way 0 unless way 1 matched

    // first invalid way wins, random only when the set is full
    always_comb begin
        if (!rd_valid[0]) begin
            victim_way = 1'b0;
        end else if (!rd_valid[1]) begin
            victim_way = 1'b1;
        end else begin
            victim_way = rand_way;
        end
    end

    assign line_addr = {req_tag, req_set, {`ICACHE_OFFSET_BITS{1'b0}}};

endmodule

//--- rtl/icache_data_store.sv
`include "icache_params.svh"

module icache_data_store
    import icache_pkg::*;
(
    input  logic                          clock,
    input  logic                          lookup_start,
    input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr,
    input  logic                          refill_en,
    input  way_t                          victim_way,
    input  line_t                         mem_rsp_data,
    output bank_word_t                    way0_word,
    output bank_word_t                    way1_word,
    output bank_word_t                    refill_word
);

    localparam int SET_NUM = 1 << `ICACHE_SET_BITS;
    localparam int BANK_LO = `ICACHE_OFFSET_BITS - `ICACHE_BANK_SEL_BITS;  // 16-byte words

    bank_word_t data_mem [`ICACHE_WAY_NUM][SET_NUM][`ICACHE_BANK_NUM];

    set_idx_t   fetch_set;
    bank_sel_t  fetch_bank;
    set_idx_t   req_set;
    bank_sel_t  req_bank;

    assign fetch_set  = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign fetch_bank = fetch_addr[BANK_LO +: `ICACHE_BANK_SEL_BITS];

    // both ways are read, the controller picks one after the tag compare
    always_ff @(posedge clock) begin
        if (lookup_start) begin
            req_set   <= fetch_set;
            req_bank  <= fetch_bank;
            way0_word <= data_mem[0][fetch_set][fetch_bank];
            way1_word <= data_mem[1][fetch_set][fetch_bank];
        end
        if (refill_en) begin
            for (int b = 0; b < `ICACHE_BANK_NUM; b++) begin
                data_mem[victim_way][req_set][b] <=
                    mem_rsp_data[b * `ICACHE_BANK_WIDTH +: `ICACHE_BANK_WIDTH];
            end
            // requested word straight from the bus
            refill_word <= mem_rsp_data[req_bank * `ICACHE_BANK_WIDTH +: `ICACHE_BANK_WIDTH];
        end
    end

endmodule

//--- rtl/icache_ctrl.sv
`include "icache_params.svh"

module icache_ctrl
    import icache_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          fetch_valid,
    input  logic                          hit,
    input  way_t                          hit_way,
    input  logic [`ICACHE_ADDR_WIDTH-1:0] line_addr,
    input  bank_word_t                    way0_word,
    input  bank_word_t                    way1_word,
    input  bank_word_t                    refill_word,
    input  logic                          mem_req_ready,
    input  logic                          mem_rsp_done,
    output logic                          fetch_ready,
    output logic                          fetch_done,
    output bank_word_t                    fetch_data,
    output logic                          lookup_start,
    output logic                          refill_en,
    output logic                          mem_req_valid,
    output logic [`ICACHE_ADDR_WIDTH-1:0] mem_req_addr
);

    icache_state_t state;
    icache_state_t next_state;

    logic lookup_hit;
    logic lookup_miss;
    logic mem_take;

    assign fetch_ready  = (state == ST_IDLE);
    assign lookup_start = fetch_valid && fetch_ready;  // fetch accept
    assign lookup_hit   = (state == ST_LOOKUP) && hit;
    assign lookup_miss  = (state == ST_LOOKUP) && !hit;
    assign mem_take     = mem_req_valid && mem_req_ready;
    assign refill_en    = (state == ST_MEM_WAIT) && mem_rsp_done;

    // one-cycle response, either from the arrays or the refill
    assign fetch_done = lookup_hit || (state == ST_REFILL);

    always_comb begin
        if (lookup_hit) begin
            fetch_data = hit_way ? way1_word : way0_word;
        end else if (state == ST_REFILL) begin
            fetch_data = refill_word;
        end else begin
            fetch_data = '0;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                if (lookup_start) next_state = ST_LOOKUP;
            end
            ST_LOOKUP: begin
                next_state = hit ? ST_IDLE : ST_MEM_REQ;
            end
            ST_MEM_REQ: begin
                if (mem_take) next_state = ST_MEM_WAIT;
            end
            ST_MEM_WAIT: begin
                if (refill_en) next_state = ST_REFILL;
            end
            ST_REFILL: begin
                next_state = ST_IDLE;
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= next_state;
        end
    end

    // request held until the memory side takes it
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            mem_req_valid <= 1'b0;
        end else if (lookup_miss) begin
            mem_req_valid <= 1'b1;
        end else if (mem_take) begin
            mem_req_valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (lookup_miss) begin
            mem_req_addr <= line_addr;  // already line aligned
        end
    end

endmodule

//--- rtl/icache_top.sv
`include "icache_params.svh"

module icache_top
    import icache_pkg::*;
(
    input  logic                          clock,
    input  logic                          reset_n,
    input  logic                          fetch_valid,
    input  logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr,
    input  logic                          mem_req_ready,
    input  logic                          mem_rsp_done,
    input  line_t                         mem_rsp_data,
    output logic                          fetch_ready,
    output logic                          fetch_done,
    output bank_word_t                    fetch_data,
    output logic                          mem_req_valid,
    output logic [`ICACHE_ADDR_WIDTH-1:0] mem_req_addr
);

    logic                          lookup_start;
    logic                          refill_en;
    logic                          hit;
    way_t                          hit_way;
    way_t                          victim_way;
    logic [`ICACHE_ADDR_WIDTH-1:0] line_addr;
    bank_word_t                    way0_word;
    bank_word_t                    way1_word;
    bank_word_t                    refill_word;

    // tags and data are looked up side by side
    icache_tag_lookup u_tag_lookup (
        .clock        (clock),
        .reset_n      (reset_n),
        .lookup_start (lookup_start),
        .fetch_addr   (fetch_addr),
        .refill_en    (refill_en),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .line_addr    (line_addr)
    );

    icache_data_store u_data_store (
        .clock        (clock),
        .lookup_start (lookup_start),
        .fetch_addr   (fetch_addr),
        .refill_en    (refill_en),
        .victim_way   (victim_way),
        .mem_rsp_data (mem_rsp_data),
        .way0_word    (way0_word),
        .way1_word    (way1_word),
        .refill_word  (refill_word)
    );

    icache_ctrl u_ctrl (
        .clock         (clock),
        .reset_n       (reset_n),
        .fetch_valid   (fetch_valid),
        .hit           (hit),
        .hit_way       (hit_way),
        .line_addr     (line_addr),
        .way0_word     (way0_word),
        .way1_word     (way1_word),
        .refill_word   (refill_word),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_done  (mem_rsp_done),
        .fetch_ready   (fetch_ready),
        .fetch_done    (fetch_done),
        .fetch_data    (fetch_data),
        .lookup_start  (lookup_start),
        .refill_en     (refill_en),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr)
    );

endmodule

//--- test/icache_chk.sv
`include "icache_params.svh"

module icache_chk
    import icache_pkg::*;
(
    input logic                          clock,
    input logic                          reset_n,
    input logic                          fetch_valid,
    input logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr,
    input logic                          fetch_ready,
    input logic                          fetch_done,
    input bank_word_t                    fetch_data,
    input logic                          mem_req_valid,
    input logic                          mem_req_ready,
    input logic [`ICACHE_ADDR_WIDTH-1:0] mem_req_addr
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SET_NUM = 1 << `ICACHE_SET_BITS;
    localparam int LINE_ID_BITS = `ICACHE_ADDR_WIDTH - `ICACHE_OFFSET_BITS;

    typedef logic [LINE_ID_BITS-1:0] line_id_t;

    int       error_count = 0;
    logic     accept;
    logic     seen_accept;
    logic     pending;     // accepted, no fetch_done yet
    logic     in_miss;
    logic [`ICACHE_ADDR_WIDTH-1:0] acc_addr;
    line_id_t res_line  [SET_NUM][2];  // lines known to be resident
    logic     res_valid [SET_NUM][2];
    int       fill_cnt  [SET_NUM];
    set_idx_t fetch_set;
    set_idx_t acc_set;
    logic     exp_hit;
    logic     exp_miss;

    // each 16-byte word holds four copies of its address xor a constant
    function automatic bank_word_t mem_rule(input logic [`ICACHE_ADDR_WIDTH-1:0] a);
        return {4{(a & ~32'hF) ^ 32'h5A5A_0000}};
    endfunction

    task automatic note_failure(input string msg);
        error_count++;
        $error("%s", msg);
    endtask

    assign accept    = fetch_valid && fetch_ready;
    assign fetch_set = fetch_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];
    assign acc_set   = acc_addr[`ICACHE_OFFSET_BITS +: `ICACHE_SET_BITS];

    // first two fills of a set land in free ways, later only the newest is certain
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            seen_accept <= 1'b0;
            pending     <= 1'b0;
            in_miss     <= 1'b0;
            acc_addr    <= '0;
            for (int s = 0; s < SET_NUM; s++) begin
                fill_cnt[s] <= 0;
                for (int w = 0; w < 2; w++) begin
                    res_line[s][w]  <= '0;
                    res_valid[s][w] <= 1'b0;
                end
            end
        end else begin
            if (accept) begin
                seen_accept <= 1'b1;
                pending     <= 1'b1;
                acc_addr    <= fetch_addr;
            end
            if (mem_req_valid && mem_req_ready) begin
                in_miss <= 1'b1;
            end
            if (fetch_done) begin
                pending <= 1'b0;
                in_miss <= 1'b0;
                if (in_miss && fill_cnt[acc_set] < 2) begin
                    res_line[acc_set][fill_cnt[acc_set]]  <= acc_addr[`ICACHE_ADDR_WIDTH-1 -: LINE_ID_BITS];
                    res_valid[acc_set][fill_cnt[acc_set]] <= 1'b1;
                    fill_cnt[acc_set] <= fill_cnt[acc_set] + 1;
                end else if (in_miss) begin
                    res_line[acc_set][0]  <= acc_addr[`ICACHE_ADDR_WIDTH-1 -: LINE_ID_BITS];
                    res_valid[acc_set][1] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        exp_hit = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (res_valid[fetch_set][w] &&
                res_line[fetch_set][w] == fetch_addr[`ICACHE_ADDR_WIDTH-1 -: LINE_ID_BITS]) begin
                exp_hit = 1'b1;
            end
        end
        exp_miss = !exp_hit && (fill_cnt[fetch_set] < 2);  // a free way means a miss
    end

    a_idle_after_reset: assert property (@(posedge clock) disable iff (!reset_n)
        !seen_accept |-> fetch_ready && !fetch_done && !mem_req_valid)
        else note_failure("fetch_ready, fetch_done or mem_req_valid wrong before first request");

    a_mem_addr: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid |-> mem_req_addr == {acc_addr[31:6], 6'b0})
        else note_failure($sformatf("%0t: mem_req_addr = %h, expected %h", $time,
            $sampled(mem_req_addr), {$sampled(acc_addr[31:6]), 6'b0}));

    a_mem_hold: assert property (@(posedge clock) disable iff (!reset_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_addr))
        else note_failure("memory request changed while mem_req_ready was low");

    a_fetch_data: assert property (@(posedge clock) disable iff (!reset_n)
        fetch_done |-> fetch_data == mem_rule(acc_addr))
        else note_failure($sformatf("%0t: fetch_data = %h, expected %h", $time,
            $sampled(fetch_data), mem_rule($sampled(acc_addr))));

    a_known_hit: assert property (@(posedge clock) disable iff (!reset_n)
        accept && exp_hit |=> fetch_done && !mem_req_valid)
        else note_failure("resident line did not hit in the cycle after accept");

    a_free_way_miss: assert property (@(posedge clock) disable iff (!reset_n)
        accept && exp_miss |=> !fetch_done)
        else note_failure("line absent from a set with a free way still hit");

    a_done_pulse: assert property (@(posedge clock) disable iff (!reset_n)
        fetch_done |=> !fetch_done)
        else note_failure("fetch_done longer than one cycle");

    a_done_per_accept: assert property (@(posedge clock) disable iff (!reset_n)
        (fetch_done |-> pending) and (fetch_ready |-> !pending))
        else note_failure("fetch_done count does not match accepted requests");

endmodule

bind icache_top icache_chk u_chk (.*);

//--- test/icache_tb.sv
`include "icache_params.svh"

module icache_tb
    import icache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF    = 2;
    localparam int NUM_RANDOM  = 60;
    localparam int NUM_REQ     = NUM_RANDOM + 5;
    localparam int CYCLE_LIMIT = 40 * NUM_REQ;

    logic                          clock = 1'b0;
    logic                          reset_n;
    logic                          fetch_valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] fetch_addr;
    logic                          mem_req_ready;
    logic                          mem_rsp_done;
    line_t                         mem_rsp_data;
    logic                          fetch_ready;
    logic                          fetch_done;
    bank_word_t                    fetch_data;
    logic                          mem_req_valid;
    logic [`ICACHE_ADDR_WIDTH-1:0] mem_req_addr;

    logic [15:0] lfsr = 16'd56383;
    int          cycles = 0;

    icache_top uut (.*);

    always #CLK_HALF clock = ~clock;

    // x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic line_t mem_line(input logic [31:0] base);
        line_t       l;
        logic [31:0] a;
        for (int b = 0; b < `ICACHE_BANK_NUM; b++) begin
            a = base + 32'(b * 16);
            l[b * `ICACHE_BANK_WIDTH +: `ICACHE_BANK_WIDTH] = {4{a ^ 32'h5A5A_0000}};
        end
        return l;
    endfunction

    // 4 tags over 4 sets is twice the capacity so lines get evicted
    function automatic logic [31:0] pick_addr();
        logic [21:0] tag;
        logic [3:0]  set;
        logic [5:0]  offset;
        tag    = 22'h2A0 + 22'(rand_bits(2));
        set    = 4'(rand_bits(2));
        offset = 6'(rand_bits(6));
        return {tag, set, offset};
    endfunction

    task automatic fetch(input logic [31:0] addr);
        @(posedge clock);
        fetch_valid <= 1'b1;
        fetch_addr  <= addr;
        @(negedge clock);
        while (!fetch_ready) @(negedge clock);
        @(posedge clock);  // accept edge
        fetch_valid <= 1'b0;
        @(negedge clock);
        while (!fetch_done) @(negedge clock);
    endtask

    // line-wide memory with back-pressure and random latency
    always begin : memory_model
        logic [31:0] req_addr;
        int          stall;
        int          latency;
        @(negedge clock);
        if (reset_n && mem_req_valid) begin
            req_addr = mem_req_addr;
            stall    = rand_bits(2);
            latency  = rand_bits(3) % 6 + 1;
            repeat (stall) @(posedge clock);
            @(posedge clock);
            mem_req_ready <= 1'b1;
            @(posedge clock);  // taking edge
            mem_req_ready <= 1'b0;
            repeat (latency - 1) @(posedge clock);
            mem_rsp_done <= 1'b1;
            mem_rsp_data <= mem_line(req_addr);
            @(posedge clock);
            mem_rsp_done <= 1'b0;
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: requests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped on timeout");
        end
    end

    always @(uut.u_chk.error_count) begin
        if (uut.u_chk.error_count != 0) begin
            $display("STATUS: FAIL");
            $fatal(1, "run stopped on first assertion failure");
        end
    end

    initial begin
        reset_n       = 1'b0;
        fetch_valid   = 1'b0;
        fetch_addr    = '0;
        mem_req_ready = 1'b0;
        mem_rsp_done  = 1'b0;
        mem_rsp_data  = '0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        // two tags into empty set 5, then both again
        fetch(32'h1000_0150);
        fetch(32'h2000_0170);
        fetch(32'h1000_0150);
        fetch(32'h2000_0174);
        fetch(32'h1000_0164);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            fetch(pick_addr());
        end
        // let the checks on the last response finish
        repeat (2) @(posedge clock);
        @(negedge clock);
        if (uut.u_chk.error_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "assertion failures recorded");
        end
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/icache_pkg.sv
rtl/icache_tag_lookup.sv
rtl/icache_data_store.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
test/icache_chk.sv
test/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/icache_pkg.sv
      - rtl/icache_tag_lookup.sv
      - rtl/icache_data_store.sv
      - rtl/icache_ctrl.sv
      - rtl/icache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/icache_chk.sv
      - test/icache_tb.sv
